// File: src.f
sort_pkg.sv
key_to_int.sv
sync_fifo.sv
data_packer.sv
write_buffer.sv
sort_write_path.sv
tb_sort_write_path.sv

// File: Makefile
# Verilator flow for the sorter write path

VERILATOR  ?= verilator
TOP        ?= tb_sort_write_path
FILELIST   ?= src.f
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
PASS_TEXT  ?= No errors

SOURCES := $(wildcard *.sv)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// File: tb_sort_write_path.sv
/*
  directed testbench of the sorter write path
  inputs change 1 ns after the rising edge and outputs are sampled there before new inputs
*/
`timescale 1ns/1ps
`default_nettype none

module tb_sort_write_path;

  import sort_pkg::*;

  localparam int OUT_DEPTH_LOG       = 4;
  localparam int WRITE_REQ_THRESHOLD = 4;
  localparam int RECS_PER_WORD       = 1 << PACK_LOG;
  localparam int TIMEOUT             = 200;
  localparam int LONG_TIMEOUT        = 3000;

  logic    CLK;
  logic    RST;
  logic    i_valid;
  record_t i_record;
  logic    i_deq;
  word_t   o_data;
  logic    o_empty;
  logic    o_full;
  logic    o_write_req;

  // model holds the converted records of the open group and the words not yet dequeued
  record_t     rec_q[$];
  word_t       word_q[$];

  sort_write_path #(
    .OUT_DEPTH_LOG       (OUT_DEPTH_LOG),
    .WRITE_REQ_THRESHOLD (WRITE_REQ_THRESHOLD)
  ) sort_write_path_i (
    .CLK         (CLK),
    .RST         (RST),
    .i_valid     (i_valid),
    .i_record    (i_record),
    .i_deq       (i_deq),
    .o_data      (o_data),
    .o_empty     (o_empty),
    .o_full      (o_full),
    .o_write_req (o_write_req)
  );

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [WORD_W-1:0] got,
                             input logic [WORD_W-1:0] exp);
    if (got !== exp) begin
      stop_on_error($sformatf("Mismatch at %0t: %s got %0h expected %0h",
                              $time, name, got, exp));
    end
  endtask

  // sign-bit keys become the negation of their 31-bit magnitude
  function automatic logic [KEY_W-1:0] convert_key(input logic [KEY_W-1:0] key);
    logic [KEY_W-1:0] mag;
    mag = {1'b0, key[KEY_W-2:0]};
    if (key[KEY_W-1]) begin
      return -mag;
    end else begin
      return key;
    end
  endfunction

  function automatic record_t random_record();
    record_t r;
    r.key     = $urandom();
    r.payload = $urandom();
    return r;
  endfunction

  // first record of a group lands in the lowest bits
  task automatic model_push(input record_t rec);
    record_t conv;
    word_t   w;
    int      k;
    conv     = rec;
    conv.key = convert_key(rec.key);
    rec_q.push_back(conv);
    if (rec_q.size() == RECS_PER_WORD) begin
      w = '0;
      for (k = 0; k < RECS_PER_WORD; k++) begin
        w[k*REC_W +: REC_W] = rec_q[k];
      end
      word_q.push_back(w);
      rec_q.delete();
    end
  endtask

  task automatic next_cycle();
    @(posedge CLK);
    #1;
  endtask

  // drives one clock of stimulus and checks a dequeued word against the model first
  task automatic drive_cycle(input logic valid, input record_t rec, input logic deq);
    word_t exp;
    if (deq) begin
      if (o_empty) begin
        stop_on_error("dequeue attempted while the word FIFO was empty");
      end
      if (word_q.size() == 0) begin
        stop_on_error("DUT presented a word that the model does not expect");
      end
      exp = word_q.pop_front();
      check_value("o_data", o_data, exp);
    end
    if (valid) begin
      model_push(rec);
    end
    i_valid  = valid;
    i_record = rec;
    i_deq    = deq;
    next_cycle();
    i_valid = 1'b0;
    i_deq   = 1'b0;
  endtask

  task automatic send_record(input record_t rec);
    int waited;
    waited = 0;
    while (o_full) begin
      next_cycle();
      waited++;
      if (waited > TIMEOUT) begin
        stop_on_error("o_full never fell while a record was waiting to be sent");
      end
    end
    drive_cycle(1'b1, rec, 1'b0);
  endtask

  task automatic wait_for_word(input string what);
    int waited;
    waited = 0;
    while (o_empty) begin
      next_cycle();
      waited++;
      if (waited > TIMEOUT) begin
        stop_on_error({"timeout, no word arrived for ", what});
      end
    end
  endtask

  task automatic wait_for_write_req(input logic level);
    int waited;
    waited = 0;
    while (o_write_req !== level) begin
      next_cycle();
      waited++;
      if (waited > TIMEOUT) begin
        stop_on_error($sformatf("timeout, o_write_req never went to %0b", level));
      end
    end
  endtask

  // dequeue every expected word and expect an empty FIFO afterwards
  task automatic drain_words();
    int waited;
    waited = 0;
    while (word_q.size() != 0) begin
      if (!o_empty) begin
        drive_cycle(1'b0, '0, 1'b1);
      end else begin
        next_cycle();
      end
      waited++;
      if (waited > LONG_TIMEOUT) begin
        stop_on_error("timeout, expected words never left the word FIFO");
      end
    end
    check_value("o_empty", o_empty, 1'b1);
  endtask

  task automatic verify_reset_state();
    check_value("o_empty", o_empty, 1'b1);
    check_value("o_full", o_full, 1'b0);
    check_value("o_write_req", o_write_req, 1'b0);
  endtask

  task automatic pack_positive_keys();
    record_t recs [4];
    word_t   direct;
    int      k;
    recs[0] = '{payload: 32'h0000_0011, key: 32'h0000_0000};
    recs[1] = '{payload: 32'h0000_0022, key: 32'h3f80_0000};
    recs[2] = '{payload: 32'h0000_0033, key: 32'h7f7f_ffff};
    recs[3] = '{payload: 32'h0000_0044, key: 32'h0000_0001};
    direct  = '0;
    for (k = 0; k < RECS_PER_WORD; k++) begin
      send_record(recs[k]);
      direct[k*REC_W +: REC_W] = recs[k];
    end
    wait_for_word("positive keys");
    check_value("o_data", o_data, direct);
    drain_words();
  endtask

  task automatic negate_negative_keys();
    record_t recs [4];
    int      k;
    recs[0] = '{payload: 32'hcafe_0000, key: 32'h8000_0000};
    recs[1] = '{payload: 32'hcafe_0001, key: 32'hffff_ffff};
    recs[2] = '{payload: 32'hcafe_0002, key: 32'hbf80_0000};
    recs[3] = '{payload: 32'hcafe_0003, key: 32'hc2c8_0000};
    for (k = 0; k < RECS_PER_WORD; k++) begin
      send_record(recs[k]);
    end
    wait_for_word("negative keys");
    // zero magnitude and the largest magnitude
    check_value("o_data key 0", o_data[0 +: KEY_W], 32'h0000_0000);
    check_value("o_data key 1", o_data[REC_W +: KEY_W], 32'h8000_0001);
    for (k = 0; k < RECS_PER_WORD; k++) begin
      check_value($sformatf("o_data payload %0d", k),
                  o_data[k*REC_W+KEY_W +: PAY_W], recs[k].payload);
    end
    drain_words();
  endtask

  task automatic raise_write_request();
    int k;
    for (k = 0; k < (WRITE_REQ_THRESHOLD - 1) * RECS_PER_WORD; k++) begin
      send_record(random_record());
    end
    // window long enough for all records to be packed
    for (k = 0; k < 30; k++) begin
      check_value("o_write_req", o_write_req, 1'b0);
      next_cycle();
    end
    for (k = 0; k < RECS_PER_WORD; k++) begin
      send_record(random_record());
    end
    wait_for_write_req(1'b1);
    drive_cycle(1'b0, '0, 1'b1);
    wait_for_write_req(1'b0);
    drain_words();
  endtask

  task automatic stall_and_drain();
    logic seen_full;
    int   waited;
    seen_full = 1'b0;
    waited    = 0;
    while (!seen_full) begin
      if (o_full) begin
        seen_full = 1'b1;
      end else begin
        drive_cycle(1'b1, random_record(), 1'b0);
      end
      waited++;
      if (waited > LONG_TIMEOUT) begin
        stop_on_error("timeout, o_full never rose while i_deq was held low");
      end
    end
    // drain while topping up the open group so it completes a word
    waited = 0;
    while (word_q.size() != 0 || rec_q.size() != 0) begin
      drive_cycle(rec_q.size() != 0 && !o_full, random_record(), !o_empty);
      waited++;
      if (waited > LONG_TIMEOUT) begin
        stop_on_error("timeout, words never drained after back-pressure");
      end
    end
    check_value("o_empty", o_empty, 1'b1);
  endtask

  task automatic mix_random_traffic();
    logic send_now;
    logic deq_now;
    int   sent;
    int   waited;
    sent   = 0;
    waited = 0;
    while (sent < 64 || word_q.size() != 0) begin
      send_now = (sent < 64) && !o_full && ($urandom_range(2) != 0);
      deq_now  = !o_empty && ($urandom_range(1) == 1);
      drive_cycle(send_now, random_record(), deq_now);
      if (send_now) begin
        sent++;
      end
      waited++;
      if (waited > LONG_TIMEOUT) begin
        stop_on_error("timeout, random traffic did not complete");
      end
    end
    check_value("o_empty", o_empty, 1'b1);
  endtask

  initial begin
    void'($urandom(32'h4f1981d4));
    RST      = 1'b1;
    i_valid  = 1'b0;
    i_record = '0;
    i_deq    = 1'b0;
    repeat (10) @(posedge CLK);
    #1;
    RST = 1'b0;
    verify_reset_state();
    pack_positive_keys();
    negate_negative_keys();
    raise_write_request();
    stall_and_drain();
    mix_random_traffic();
    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: sort_write_path.sv
/*
  write path of the record sorter, converter followed by the write buffer
  upstream must hold i_valid low while o_full is high
*/
`timescale 1ns/1ps
`default_nettype none

module sort_write_path #(
  parameter int OUT_DEPTH_LOG       = 4,
  parameter int WRITE_REQ_THRESHOLD = 4
) (
  input  wire                CLK,
  input  wire                RST,
  input  wire                i_valid,
  input  wire sort_pkg::record_t i_record,
  input  wire                i_deq,
  output sort_pkg::word_t    o_data,
  output logic               o_empty,
  output logic               o_full,
  output logic               o_write_req
);

  import sort_pkg::*;

  // converted records, 3 cycles behind the input
  logic    conv_valid;
  record_t conv_record;

  key_to_int key_to_int_i (
    .CLK      (CLK),
    .RST      (RST),
    .i_valid  (i_valid),
    .i_record (i_record),
    .o_valid  (conv_valid),
    .o_record (conv_record)
  );

  write_buffer #(
    .OUT_DEPTH_LOG       (OUT_DEPTH_LOG),
    .WRITE_REQ_THRESHOLD (WRITE_REQ_THRESHOLD)
  ) write_buffer_i (
    .CLK         (CLK),
    .RST         (RST),
    .i_valid     (conv_valid),
    .i_record    (conv_record),
    .i_deq       (i_deq),
    .o_data      (o_data),
    .o_empty     (o_empty),
    .o_full      (o_full),
    .o_write_req (o_write_req)
  );

endmodule

`default_nettype wire

// File: write_buffer.sv
/*
  record FIFO, packer and word FIFO of the write path
  WRITE_REQ_THRESHOLD must be a power of two no larger than the word FIFO depth
*/
`timescale 1ns/1ps
`default_nettype none

module write_buffer #(
  parameter int OUT_DEPTH_LOG       = 4,
  parameter int WRITE_REQ_THRESHOLD = 4
) (
  input  wire                CLK,
  input  wire                RST,
  input  wire                i_valid,
  input  wire sort_pkg::record_t i_record,
  input  wire                i_deq,
  output sort_pkg::word_t    o_data,
  output logic               o_empty,
  output logic               o_full,
  output logic               o_write_req
);

  import sort_pkg::*;

  localparam int REQ_LOG = $clog2(WRITE_REQ_THRESHOLD);

  // record FIFO
  record_t             in_dout;
  logic                in_deq;
  logic                in_empty;
  logic                in_full;
  logic [IN_DEPTH_LOG:0] in_count;

  // packer
  logic                pack_valid;
  word_t               pack_word;

  // word FIFO
  logic                out_full;
  logic [OUT_DEPTH_LOG:0] out_count;

  logic                write_req_q;

  sync_fifo #(
    .entry_t   (record_t),
    .DEPTH_LOG (IN_DEPTH_LOG)
  ) in_fifo_i (
    .CLK     (CLK),
    .RST     (RST),
    .i_enq   (i_valid),
    .i_deq   (in_deq),
    .i_din   (i_record),
    .o_dout  (in_dout),
    .o_empty (in_empty),
    .o_full  (in_full),
    .o_count (in_count)
  );

  // drain records only while the word FIFO has room
  assign in_deq = !in_empty && !out_full;

  data_packer data_packer_i (
    .CLK      (CLK),
    .RST      (RST),
    .i_valid  (in_deq),
    .i_record (in_dout),
    .o_valid  (pack_valid),
    .o_word   (pack_word)
  );

  sync_fifo #(
    .entry_t   (word_t),
    .DEPTH_LOG (OUT_DEPTH_LOG)
  ) out_fifo_i (
    .CLK     (CLK),
    .RST     (RST),
    .i_enq   (pack_valid),
    .i_deq   (i_deq),
    .i_din   (pack_word),
    .o_dout  (o_data),
    .o_empty (o_empty),
    .o_full  (out_full),
    .o_count (out_count)
  );

  // 4 or more queued records, leaves room for the 3 in the converter
  assign o_full = |in_count[IN_DEPTH_LOG:2];

  // count >= threshold, valid since the threshold is a power of two
  always_ff @(posedge CLK) begin
    if (RST) begin
      write_req_q <= 1'b0;
    end else begin
      write_req_q <= |out_count[OUT_DEPTH_LOG:REQ_LOG];
    end
  end

  assign o_write_req = write_req_q;

  // the record FIFO can absorb the converter backlog once o_full rises
  a_in_fifo_no_overflow : assert property (
    @(posedge CLK) disable iff (RST) !(in_full && i_valid)
  ) else $error("record FIFO overflow, upstream ignored o_full");

  a_threshold_fits : assert property (
    @(posedge CLK) WRITE_REQ_THRESHOLD <= (1 << OUT_DEPTH_LOG)
  ) else $error("write request threshold exceeds the word FIFO depth");

endmodule

`default_nettype wire

// File: data_packer.sv
/*
  packs four consecutive records into one memory word
  a partial group waits until its fourth record arrives
*/
`timescale 1ns/1ps
`default_nettype none

module data_packer (
  input  wire                CLK,
  input  wire                RST,
  input  wire                i_valid,
  input  wire sort_pkg::record_t i_record,
  output logic               o_valid,
  output sort_pkg::word_t    o_word
);

  import sort_pkg::*;

  word_t               pack_q;
  logic [PACK_LOG-1:0] slot;

  // new records enter at the top, so the first ends in the lowest slot
  always_ff @(posedge CLK) begin
    if (i_valid) begin
      pack_q <= {i_record, pack_q[WORD_W-1:REC_W]};
    end
  end

  always_ff @(posedge CLK) begin
    if (RST) begin
      slot <= '0;
    end else if (i_valid) begin
      slot <= slot + 1'b1;
    end
  end

  // word complete on the record that fills the last slot
  always_ff @(posedge CLK) begin
    if (RST) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= i_valid && (&slot);
    end
  end

  assign o_word = pack_q;

endmodule

`default_nettype wire

// File: sync_fifo.sv
/*
  show-ahead FIFO, the head is valid whenever o_empty is low
  enqueue while full and dequeue while empty are illegal and not absorbed
*/
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
  parameter type entry_t   = logic [7:0],
  parameter int  DEPTH_LOG = 3
) (
  input  wire             CLK,
  input  wire             RST,
  input  wire             i_enq,
  input  wire             i_deq,
  input  wire entry_t     i_din,
  output entry_t          o_dout,
  output logic            o_empty,
  output logic            o_full,
  output logic [DEPTH_LOG:0] o_count
);

  localparam int DEPTH = 1 << DEPTH_LOG;

  entry_t               mem [DEPTH];
  logic [DEPTH_LOG-1:0] wr_ptr;
  logic [DEPTH_LOG-1:0] rd_ptr;
  logic [DEPTH_LOG:0]   count;

  // storage, no reset on the payload
  always_ff @(posedge CLK) begin
    if (i_enq) begin
      mem[wr_ptr] <= i_din;
    end
  end

  // pointers wrap naturally at the power-of-two depth
  always_ff @(posedge CLK) begin
    if (RST) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (i_enq) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (i_deq) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // occupancy
  always_ff @(posedge CLK) begin
    if (RST) begin
      count <= '0;
    end else begin
      case ({i_enq, i_deq})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // head read straight from the array
  assign o_dout  = mem[rd_ptr];
  assign o_count = count;
  assign o_empty = (count == '0);
  // count never exceeds DEPTH, so the top bit alone means full
  assign o_full  = count[DEPTH_LOG];

  // the caller must respect the flags
  a_no_enq_when_full : assert property (
    @(posedge CLK) disable iff (RST) !(i_enq && o_full && !i_deq)
  ) else $error("enqueue into a full FIFO");

  a_no_deq_when_empty : assert property (
    @(posedge CLK) disable iff (RST) !(i_deq && o_empty)
  ) else $error("dequeue from an empty FIFO");

endmodule

`default_nettype wire

// File: key_to_int.sv
/*
  float key to signed-sortable integer, fixed latency of 3 cycles
  negative keys become the negation of their low 31 bits, payload untouched
*/
`timescale 1ns/1ps
`default_nettype none

module key_to_int (
  input  wire                CLK,
  input  wire                RST,
  input  wire                i_valid,
  input  wire sort_pkg::record_t i_record,
  output logic               o_valid,
  output sort_pkg::record_t  o_record
);

  import sort_pkg::*;

  logic             neg_s1;
  logic             neg_s2;
  logic [KEY_W-1:0] inv_s1;
  logic [KEY_W-1:0] plus_s2;
  logic [KEY_W-1:0] key_s1;
  logic [KEY_W-1:0] key_s2;
  logic [PAY_W-1:0] pay_s1;
  logic [PAY_W-1:0] pay_s2;
  logic             valid_s1;
  logic             valid_s2;

  // stage 1: sign and inverted magnitude with the sign bit cleared
  always_ff @(posedge CLK) begin
    neg_s1 <= i_record.key[KEY_W-1];
    inv_s1 <= ~{1'b0, i_record.key[KEY_W-2:0]};
    key_s1 <= i_record.key;
    pay_s1 <= i_record.payload;
  end

  // stage 2: finish the two's complement
  always_ff @(posedge CLK) begin
    neg_s2  <= neg_s1;
    plus_s2 <= inv_s1 + 1'b1;
    key_s2  <= key_s1;
    pay_s2  <= pay_s1;
  end

  // stage 3: pick the negated value for sign-bit keys
  always_ff @(posedge CLK) begin
    o_record.key     <= neg_s2 ? plus_s2 : key_s2;
    o_record.payload <= pay_s2;
  end

  // valid travels alongside the data
  always_ff @(posedge CLK) begin
    if (RST) begin
      valid_s1 <= 1'b0;
      valid_s2 <= 1'b0;
      o_valid  <= 1'b0;
    end else begin
      valid_s1 <= i_valid;
      valid_s2 <= valid_s1;
      o_valid  <= valid_s2;
    end
  end

endmodule

`default_nettype wire

// File: sort_pkg.sv
/*
  shared widths and types of the sorter write path
  a record is one 32-bit key and one 32-bit payload, four records per memory word
*/
`default_nettype none

package sort_pkg;

  // record fields
  localparam int KEY_W = 32;
  localparam int PAY_W = 32;
  localparam int REC_W = KEY_W + PAY_W;

  // records per memory word, log scale
  localparam int PACK_LOG = 2;
  localparam int WORD_W   = REC_W << PACK_LOG;

  // input FIFO holds 8 records
  localparam int IN_DEPTH_LOG = 3;

  // payload in the upper half, key in the lower half
  typedef struct packed {
    logic [PAY_W-1:0] payload;
    logic [KEY_W-1:0] key;
  } record_t;

  // first record of a word sits in the lowest REC_W bits
  typedef logic [WORD_W-1:0] word_t;

endpackage

`default_nettype wire
